// File: files.f
source/video_pkg.sv
source/kernel_pkg.sv
source/blur_control.sv
source/line_window.sv
source/channel_convolver.sv
source/pixel_normalizer.sv
source/blur_filter.sv
tb/tb_clock.sv
tb/tb_blur_filter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the blur filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -f files.f --top-module tb_blur_filter \
    -Mdir obj_dir -o tb_blur_filter
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_blur_filter > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "tests failed" "$log_file"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: source/blur_control.sv
`timescale 1ns/1ps

module blur_control (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [2:0]              kernel_sel,
    input  video_pkg::stream_ctrl_t ctrl_in,
    input  video_pkg::rgb444_t      pixel_in,
    output kernel_pkg::kernel_mode_e conv_mode,
    output kernel_pkg::beat_tag_t   out_tag
);

    localparam int tag_stages = 3;

    kernel_pkg::kernel_mode_e sel_mode;
    kernel_pkg::kernel_mode_e mode_q;
    kernel_pkg::kernel_mode_e beat_mode;
    kernel_pkg::beat_tag_t    tag_in;
    kernel_pkg::beat_tag_t    tag_q [1:tag_stages];
    logic                     sop_beat;

    // Select decode, unknown codes map to bypass
    always_comb begin
        case (kernel_sel)
            3'd1:    sel_mode = kernel_pkg::KERNEL_3X3;
            3'd2:    sel_mode = kernel_pkg::KERNEL_5X5;
            default: sel_mode = kernel_pkg::KERNEL_BYPASS;
        endcase
    end

    assign sop_beat = ctrl_in.valid && ctrl_in.sop;

    // Mode holds for the whole packet
    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q <= kernel_pkg::KERNEL_BYPASS;
        end else if (sop_beat) begin
            mode_q <= sel_mode;
        end
    end

    // SOP beat already runs with the new mode
    assign beat_mode = sop_beat ? sel_mode : mode_q;

    assign tag_in.ctrl  = ctrl_in;
    assign tag_in.mode  = beat_mode;
    assign tag_in.pixel = pixel_in;

    // Tags advance every clock so idle cycles stay idle at the output
    always_ff @(posedge clk) begin
        tag_q[1] <= tag_in;
        for (int i = 2; i <= tag_stages; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
        if (rst) begin
            for (int i = 1; i <= tag_stages; i++) begin
                tag_q[i].ctrl <= '0;
            end
        end
    end

    // Stage 1 lines up with the registered window
    assign conv_mode = tag_q[1].mode;

    // Stage 3 lines up with the finished sums
    assign out_tag = tag_q[tag_stages];

endmodule

// File: source/blur_filter.sv
`timescale 1ns/1ps

module blur_filter (
    input  logic               clk,
    input  logic               rst,
    input  logic [2:0]         kernel_sel,
    input  logic               ready_in,
    input  logic               valid_in,
    input  logic               sop_in,
    input  logic               eop_in,
    input  video_pkg::rgb444_t data_in,
    output logic               ready_out,
    output logic               valid_out,
    output logic               sop_out,
    output logic               eop_out,
    output video_pkg::rgb444_t data_out
);

    video_pkg::stream_ctrl_t    ctrl_in;
    video_pkg::stream_ctrl_t    ctrl_out;
    video_pkg::channel_window_t red_win;
    video_pkg::channel_window_t green_win;
    video_pkg::channel_window_t blue_win;
    kernel_pkg::kernel_mode_e   conv_mode;
    kernel_pkg::beat_tag_t      norm_tag;

    logic [kernel_pkg::conv_sum_width-1:0] red_sum;
    logic [kernel_pkg::conv_sum_width-1:0] green_sum;
    logic [kernel_pkg::conv_sum_width-1:0] blue_sum;

    // No stalling inside, back-pressure goes straight to the source
    assign ready_out = ready_in;

    assign ctrl_in = '{valid: valid_in, sop: sop_in, eop: eop_in};

    blur_control u_blur_control (
        .clk        (clk),
        .rst        (rst),
        .kernel_sel (kernel_sel),
        .ctrl_in    (ctrl_in),
        .pixel_in   (data_in),
        .conv_mode  (conv_mode),
        .out_tag    (norm_tag)
    );

    line_window u_line_window (
        .clk       (clk),
        .valid     (valid_in),
        .pixel_in  (data_in),
        .red_win   (red_win),
        .green_win (green_win),
        .blue_win  (blue_win)
    );

    channel_convolver u_conv_red   (.clk(clk), .mode(conv_mode), .window(red_win),   .sum(red_sum));
    channel_convolver u_conv_green (.clk(clk), .mode(conv_mode), .window(green_win), .sum(green_sum));
    channel_convolver u_conv_blue  (.clk(clk), .mode(conv_mode), .window(blue_win),  .sum(blue_sum));

    pixel_normalizer u_pixel_normalizer (
        .clk       (clk),
        .rst       (rst),
        .tag       (norm_tag),
        .red_sum   (red_sum),
        .green_sum (green_sum),
        .blue_sum  (blue_sum),
        .ctrl_out  (ctrl_out),
        .data_out  (data_out)
    );

    assign valid_out = ctrl_out.valid;
    assign sop_out   = ctrl_out.sop;
    assign eop_out   = ctrl_out.eop;

endmodule

// File: source/channel_convolver.sv
`timescale 1ns/1ps

module channel_convolver (
    input  logic                                  clk,
    input  kernel_pkg::kernel_mode_e              mode,
    input  video_pkg::channel_window_t            window,
    output logic [kernel_pkg::conv_sum_width-1:0] sum
);

    localparam int ws = video_pkg::window_size;

    typedef logic [kernel_pkg::conv_sum_width-1:0] sum_t;

    sum_t row_next [0:ws-1];
    sum_t row_sum  [0:ws-1];

    // Weighted row sums for the selected kernel
    always_comb begin
        for (int r = 0; r < ws; r++) begin
            row_next[r] = '0;
        end
        case (mode)
            kernel_pkg::KERNEL_5X5: begin
                for (int r = 0; r < ws; r++) begin
                    for (int c = 0; c < ws; c++) begin
                        row_next[r] = row_next[r]
                            + sum_t'(window[r][c]) * sum_t'(kernel_pkg::weights_5x5[r][c]);
                    end
                end
            end
            kernel_pkg::KERNEL_3X3: begin
                // Newest 3x3 corner of the window
                for (int r = 2; r < ws; r++) begin
                    for (int c = 2; c < ws; c++) begin
                        row_next[r] = row_next[r]
                            + sum_t'(window[r][c])
                            * sum_t'(kernel_pkg::weights_3x3[r-2][c-2]);
                    end
                end
            end
            default: begin
                // Bypass, result unused
            end
        endcase
    end

    // Stage 1
    always_ff @(posedge clk) begin
        for (int r = 0; r < ws; r++) begin
            row_sum[r] <= row_next[r];
        end
    end

    // Stage 2 adds the rows
    always_ff @(posedge clk) begin
        sum <= row_sum[0] + row_sum[1] + row_sum[2] + row_sum[3] + row_sum[4];
    end

endmodule

// File: source/kernel_pkg.sv
package kernel_pkg;

    // Filter modes, anything undecoded falls back to bypass
    typedef enum logic [1:0] {
        KERNEL_BYPASS = 2'd0,
        KERNEL_3X3    = 2'd1,
        KERNEL_5X5    = 2'd2
    } kernel_mode_e;

    // Weights sum to 64
    localparam logic [0:4][0:4][2:0] weights_5x5 = '{
        '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1},
        '{3'd2, 3'd3, 3'd4, 3'd3, 3'd2},
        '{3'd3, 3'd4, 3'd4, 3'd4, 3'd3},
        '{3'd2, 3'd3, 3'd4, 3'd3, 3'd2},
        '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1}
    };

    // Weights sum to 32
    localparam logic [0:2][0:2][2:0] weights_3x3 = '{
        '{3'd3, 3'd4, 3'd3},
        '{3'd4, 3'd4, 3'd4},
        '{3'd3, 3'd4, 3'd3}
    };

    localparam int shift_3x3 = 5;
    localparam int shift_5x5 = 6;

    // Worst case 15 * 64 = 960
    localparam int conv_sum_width = 10;

    // Per-beat sideband carried next to the datapath
    typedef struct packed {
        video_pkg::stream_ctrl_t ctrl;
        kernel_mode_e            mode;
        video_pkg::rgb444_t      pixel;
    } beat_tag_t;

endpackage

// File: source/line_window.sv
`timescale 1ns/1ps

module line_window (
    input  logic                       clk,
    input  logic                       valid,
    input  video_pkg::rgb444_t         pixel_in,
    output video_pkg::channel_window_t red_win,
    output video_pkg::channel_window_t green_win,
    output video_pkg::channel_window_t blue_win
);

    localparam int ws    = video_pkg::window_size;
    localparam int depth = video_pkg::history_depth;

    // Index is the age in beats, age 0 is pixel_in itself
    video_pkg::rgb444_t history [1:depth-1];
    video_pkg::rgb444_t tap_pix [0:ws-1][0:ws-1];

    // Tap selection from the continuous history
    for (genvar r = 0; r < ws; r++) begin : g_row
        for (genvar c = 0; c < ws; c++) begin : g_col
            localparam int age = (ws - 1 - r) * video_pkg::line_width + (ws - 1 - c);
            if (age == 0) begin : g_newest
                assign tap_pix[r][c] = pixel_in;
            end else begin : g_hist
                assign tap_pix[r][c] = history[age];
            end
        end
    end

    // Shift only on real beats so gaps leave the window alone
    always_ff @(posedge clk) begin
        if (valid) begin
            history[1] <= pixel_in;
            for (int i = 2; i < depth; i++) begin
                history[i] <= history[i-1];
            end
        end
    end

    // Window registers, split per channel
    always_ff @(posedge clk) begin
        if (valid) begin
            for (int r = 0; r < ws; r++) begin
                for (int c = 0; c < ws; c++) begin
                    red_win[r][c]   <= tap_pix[r][c].red;
                    green_win[r][c] <= tap_pix[r][c].green;
                    blue_win[r][c]  <= tap_pix[r][c].blue;
                end
            end
        end
    end

endmodule

// File: source/pixel_normalizer.sv
`timescale 1ns/1ps

module pixel_normalizer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  kernel_pkg::beat_tag_t                 tag,
    input  logic [kernel_pkg::conv_sum_width-1:0] red_sum,
    input  logic [kernel_pkg::conv_sum_width-1:0] green_sum,
    input  logic [kernel_pkg::conv_sum_width-1:0] blue_sum,
    output video_pkg::stream_ctrl_t               ctrl_out,
    output video_pkg::rgb444_t                    data_out
);

    video_pkg::rgb444_t pixel_next;

    // Divide by the kernel weight total, or pass the raw pixel
    always_comb begin
        case (tag.mode)
            kernel_pkg::KERNEL_5X5: begin
                pixel_next.red   = 4'(red_sum   >> kernel_pkg::shift_5x5);
                pixel_next.green = 4'(green_sum >> kernel_pkg::shift_5x5);
                pixel_next.blue  = 4'(blue_sum  >> kernel_pkg::shift_5x5);
            end
            kernel_pkg::KERNEL_3X3: begin
                pixel_next.red   = 4'(red_sum   >> kernel_pkg::shift_3x3);
                pixel_next.green = 4'(green_sum >> kernel_pkg::shift_3x3);
                pixel_next.blue  = 4'(blue_sum  >> kernel_pkg::shift_3x3);
            end
            default: pixel_next = tag.pixel;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_out <= '0;
        end else begin
            ctrl_out <= tag.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= pixel_next;
    end

endmodule

// File: source/video_pkg.sv
package video_pkg;

    // Frame geometry
    localparam int line_width = 320;

    // Largest kernel edge, also the window edge
    localparam int window_size = 5;

    // Four full lines plus five pixels, newest pixel included
    localparam int history_depth = 4 * line_width + window_size;

    // One RGB444 pixel, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    // 5x5 taps of one channel
    // [r][c] is (4-r) lines and (4-c) pixels older than the newest pixel
    typedef logic [0:window_size-1][0:window_size-1][3:0] channel_window_t;

    // Stream strobes
    typedef struct packed {
        logic valid;
        logic sop;
        logic eop;
    } stream_ctrl_t;

endpackage

// File: tb/tb_blur_filter.sv
`timescale 1ns/1ps

module tb_blur_filter;

    localparam int total_beats = 400 + 1600 + 1600 + 300 + 1300 + 1300 + 50;
    localparam int watchdog_ns = 2 * total_beats * 20 + 10000;
    localparam int latency = 4;
    localparam int lw = video_pkg::line_width;
    localparam logic [31:0] lfsr_seed = 32'h9f04;

    localparam int w5 [5][5] = '{'{1, 2, 3, 2, 1}, '{2, 3, 4, 3, 2}, '{3, 4, 4, 4, 3},
                                 '{2, 3, 4, 3, 2}, '{1, 2, 3, 2, 1}};
    localparam int w3 [3][3] = '{'{3, 4, 3}, '{4, 4, 4}, '{3, 4, 3}};

    typedef struct packed {
        video_pkg::rgb444_t data;
        logic               sop;
        logic               eop;
        logic               check;
        logic [31:0]        cycle;
    } expect_t;

    logic               clk;
    logic               rst;
    logic [2:0]         kernel_sel;
    logic               ready_in;
    logic               valid_in;
    logic               sop_in;
    logic               eop_in;
    video_pkg::rgb444_t data_in;
    logic               ready_out;
    logic               valid_out;
    logic               sop_out;
    logic               eop_out;
    video_pkg::rgb444_t data_out;

    // Reference model state
    video_pkg::rgb444_t hist [0:16383];
    int                 hist_count = 0;
    int                 model_size = 1;
    expect_t            expect_q [$];
    expect_t            out_entry;
    video_pkg::rgb444_t last_out;

    logic [15:0] lfsr_state = lfsr_seed[15:0];
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    tb_clock u_tb_clock (.clk(clk), .rst(rst));

    blur_filter u_blur_filter (
        .clk        (clk),
        .rst        (rst),
        .kernel_sel (kernel_sel),
        .ready_in   (ready_in),
        .valid_in   (valid_in),
        .sop_in     (sop_in),
        .eop_in     (eop_in),
        .data_in    (data_in),
        .ready_out  (ready_out),
        .valid_out  (valid_out),
        .sop_out    (sop_out),
        .eop_out    (eop_out),
        .data_out   (data_out)
    );

    always @(posedge clk) cycle_count++;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [11:0] take_bits(input int count);
        logic [11:0] value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[10:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    // Kernel edge for a select code (1 for bypass)
    function automatic int decode_size(input logic [2:0] sel);
        case (sel)
            3'd1:    return 3;
            3'd2:    return 5;
            default: return 1;
        endcase
    endfunction

    // Weighted mean of the window ending at history index n
    function automatic video_pkg::rgb444_t blur_expected(input int n, input int size);
        int r_sum = 0;
        int g_sum = 0;
        int b_sum = 0;
        int w;
        int age;
        int lo;
        int norm;
        video_pkg::rgb444_t p;
        video_pkg::rgb444_t result;
        lo = 5 - size;
        norm = (size == 5) ? 64 : 32;
        for (int r = lo; r < 5; r++) begin
            for (int c = lo; c < 5; c++) begin
                if (size == 5) begin
                    w = w5[r][c];
                end else begin
                    w = w3[r-2][c-2];
                end
                age = (4 - r) * lw + (4 - c);
                p = hist[n - age];
                r_sum += w * int'(p.red);
                g_sum += w * int'(p.green);
                b_sum += w * int'(p.blue);
            end
        end
        result.red   = 4'(r_sum / norm);
        result.green = 4'(g_sum / norm);
        result.blue  = 4'(b_sum / norm);
        return result;
    endfunction

    task automatic record_beat(input logic sop, input logic eop, input video_pkg::rgb444_t pix,
                               input logic [2:0] sel);
        expect_t entry;
        if (sop) begin
            model_size = decode_size(sel);
        end
        hist[hist_count] = pix;
        entry.sop   = sop;
        entry.eop   = eop;
        entry.cycle = 32'(cycle_count + latency);
        entry.data  = pix;
        if (model_size == 5) begin
            entry.check = (hist_count + 1 >= video_pkg::history_depth);
        end else if (model_size == 3) begin
            entry.check = (hist_count + 1 >= 2 * lw + 3);
        end else begin
            entry.check = 1'b1;
        end
        if (model_size != 1 && entry.check) begin
            entry.data = blur_expected(hist_count, model_size);
        end
        expect_q.push_back(entry);
        hist_count++;
    endtask

    task automatic drive_cycle(input logic v, input logic s, input logic e,
                               input video_pkg::rgb444_t pix, input logic [2:0] sel);
        @(posedge clk);
        #1;
        valid_in   = v;
        sop_in     = s;
        eop_in     = e;
        data_in    = pix;
        kernel_sel = sel;
        if (v) begin
            record_beat(s, e, pix, sel);
        end
    endtask

    // Select switches to late_sel from beat switch_at on
    task automatic send_packet(input int length, input logic [2:0] sel,
                               input logic [2:0] late_sel, input int switch_at, input bit gaps,
                               input bit flat, input video_pkg::rgb444_t colour);
        video_pkg::rgb444_t pix;
        logic [2:0]         cur_sel;
        for (int i = 0; i < length; i++) begin
            pix = flat ? colour : take_bits(12);
            cur_sel = (i >= switch_at) ? late_sel : sel;
            drive_cycle(1'b1, i == 0, i == length - 1, pix, cur_sel);
            if (gaps && take_bits(1) == 12'd1) begin
                drive_cycle(1'b0, 1'b0, 1'b0, 12'h000, cur_sel);
            end
        end
    endtask

    task automatic drain_outputs;
        int waited = 0;
        while (expect_q.size() != 0 && waited < 16) begin
            drive_cycle(1'b0, 1'b0, 1'b0, 12'h000, kernel_sel);
            waited++;
        end
        if (expect_q.size() != 0) begin
            error_count++;
            $display("%0d expected output beats never arrived", expect_q.size());
            expect_q.delete();
        end
    endtask

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (valid_out) begin
                if (expect_q.size() == 0) begin
                    error_count++;
                    $display("Output beat at %0t ns with no matching input beat", $time);
                end else begin
                    out_entry = expect_q.pop_front();
                    check_equal(32'(cycle_count), out_entry.cycle, "output cycle");
                    check_equal(32'(sop_out), 32'(out_entry.sop), "sop_out");
                    check_equal(32'(eop_out), 32'(out_entry.eop), "eop_out");
                    if (out_entry.check) begin
                        check_equal(32'(data_out), 32'(out_entry.data), "data_out");
                    end
                    last_out = data_out;
                end
            end else begin
                check_equal(32'({sop_out, eop_out}), 32'd0, "strobes without valid_out");
            end
        end
    end

    task automatic reset_and_ready;
        ready_in = 1'b0;
        #1;
        check_equal(32'(ready_out), 32'd0, "ready_out low");
        ready_in = 1'b1;
        #1;
        check_equal(32'(ready_out), 32'd1, "ready_out high");
        @(negedge clk);
        while (rst) begin
            check_equal(32'({valid_out, sop_out, eop_out}), 32'd0, "strobes in reset");
            @(negedge clk);
        end
        check_equal(32'({valid_out, sop_out, eop_out}), 32'd0, "strobes after reset");
    endtask

    task automatic bypass_packet;
        send_packet(400, 3'd0, 3'd0, 0, 1'b0, 1'b0, 12'h000);
        drain_outputs();
    endtask

    task automatic random_3x3_packet;
        send_packet(1600, 3'd1, 3'd1, 0, 1'b0, 1'b0, 12'h000);
        drain_outputs();
    endtask

    task automatic gapped_5x5_packet;
        send_packet(1600, 3'd2, 3'd2, 0, 1'b1, 1'b0, 12'h000);
        drain_outputs();
    endtask

    task automatic mode_latch_and_flat_field;
        video_pkg::rgb444_t colour;
        colour = 12'h5a3;
        // Model keeps the SOP mode while the select moves mid-packet
        send_packet(300, 3'd1, 3'd2, 100, 1'b0, 1'b0, 12'h000);
        drain_outputs();
        send_packet(1300, 3'd1, 3'd5, 600, 1'b0, 1'b1, colour);
        drain_outputs();
        check_equal(32'(last_out), 32'(colour), "flat field 3x3");
        send_packet(1300, 3'd2, 3'd0, 650, 1'b0, 1'b1, colour);
        drain_outputs();
        check_equal(32'(last_out), 32'(colour), "flat field 5x5");
        // Undecoded select runs as bypass
        send_packet(50, 3'd5, 3'd5, 0, 1'b0, 1'b0, 12'h000);
        drain_outputs();
    endtask

    initial begin
        kernel_sel = 3'd0;
        ready_in   = 1'b1;
        valid_in   = 1'b0;
        sop_in     = 1'b0;
        eop_in     = 1'b0;
        data_in    = 12'h000;
        reset_and_ready();
        bypass_packet();
        random_3x3_packet();
        gapped_5x5_packet();
        mode_latch_and_flat_field();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #watchdog_ns;
        $display("Watchdog expired: the run did not finish in time");
        $display("tests failed");
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int half_period = 10;
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release just after an edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule
